// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 64;                 // register and address width

    // major opcodes, only the ones the core decodes
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_opimm  = 7'b0010011,               // addi only
        op_load   = 7'b0000011,               // ld only
        op_store  = 7'b0100011,               // sd only
        op_system = 7'b1110011                // csrrw, mret
    } rv_opcode_e;

    // machine csrs that exist in the core
    typedef enum logic [11:0] {
        csr_mstatus = 12'h300,
        csr_mtvec   = 12'h305,
        csr_mepc    = 12'h341
    } csr_addr_e;

    localparam int mstatus_mie_bit = 3;       // global machine irq enable

    // funct3 selects
    localparam logic [2:0] funct3_addi  = 3'd0;
    localparam logic [2:0] funct3_ld_sd = 3'd3;   // doubleword
    localparam logic [2:0] funct3_csrrw = 3'd1;
    localparam logic [2:0] funct3_priv  = 3'd0;   // mret lives here

    localparam logic [11:0] funct12_mret = 12'h302;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

// File: verilog/soc_map_pkg.sv
package soc_map_pkg;

    // address map, each region is one 4k page
    localparam logic [63:0] reset_vector = 64'h0000_0000_0000_0080;
    localparam logic [63:0] ram_base     = 64'h0000_0000_0000_1000;
    localparam logic [63:0] key_base     = 64'h0000_0000_0000_2000;
    localparam logic [63:0] art_base     = 64'h0000_0000_0000_3000;
    localparam int          region_bits  = 12;     // page offset bits

    localparam int ram_words = 16;                 // 64-bit words
    localparam int ram_aw    = $clog2(ram_words);
    localparam int rom_words = 64;                 // 32-bit instructions
    localparam int rom_aw    = $clog2(rom_words);

    // peripheral port widths
    localparam int key_width = 64;
    localparam int art_width = 8;                  // one character

    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic        write;                        // 1 = sd, 0 = ld
        logic        valid;
    } bus_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        valid;                        // read data returned
    } bus_rsp_t;

endpackage

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, soc_map_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     instr,        // from rom, combinational
    output logic [xlen-1:0] pc,           // fetch address
    output bus_req_t        bus_req,
    input  logic            bus_ready,
    input  bus_rsp_t        bus_rsp,
    input  logic            irq_pending,
    output logic            irq_ack,      // one cycle on handler entry
    output logic            heartbeat
);

    typedef enum logic [1:0] {idle, wait_accept, wait_data} bus_step_e;

    logic [31:0]     ir;                  // execute stage instruction
    logic            bubble;              // ir is stale after a redirect
    bus_step_e       step;
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] mstatus, mtvec, mepc;

    rv_opcode_e      opcode;
    csr_addr_e       csr_sel;
    logic [2:0]      funct3;
    logic [4:0]      rd, rs1, rs2;
    logic [xlen-1:0] imm_i, imm_s, imm_u;
    logic [xlen-1:0] rs1_val, rs2_val, csr_rdata, rf_wdata;
    logic            is_load, is_store, mem_op, mem_done, stall;
    logic            is_csrrw, is_mret, take_irq, rf_we;

    // field extraction
    assign opcode  = rv_opcode_e'(ir[6:0]);
    assign csr_sel = csr_addr_e'(ir[31:20]);
    assign funct3  = ir[14:12];
    assign rd      = ir[11:7];
    assign rs1     = ir[19:15];
    assign rs2     = ir[24:20];
    assign imm_i   = {{52{ir[31]}}, ir[31:20]};
    assign imm_s   = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u   = {{32{ir[31]}}, ir[31:12], 12'b0};

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];   // x0 hardwired
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign is_load  = !bubble && opcode == op_load && funct3 == funct3_ld_sd;
    assign is_store = !bubble && opcode == op_store && funct3 == funct3_ld_sd;
    assign mem_op   = is_load || is_store;
    assign is_csrrw = !bubble && opcode == op_system && funct3 == funct3_csrrw;
    assign is_mret  = !bubble && opcode == op_system && funct3 == funct3_priv
                      && ir[31:20] == funct12_mret;

    // sd ends on acceptance, ld on the returned data
    assign mem_done = (step == wait_accept && bus_ready && is_store)
                    || (step == wait_data && bus_rsp.valid);
    assign stall    = mem_op && !mem_done;          // freeze pc and ir

    // a load not yet accepted has no side effects, so it may be dropped
    assign take_irq = irq_pending && mstatus[mstatus_mie_bit] && !bubble
                      && (step == idle || (step == wait_accept && is_load && !bus_ready));

    always_comb begin
        case (csr_sel)
            csr_mstatus: csr_rdata = mstatus;
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            default:     csr_rdata = '0;
        endcase
    end

    // writeback select
    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = imm_u;
        if (!bubble && !take_irq) begin
            case (opcode)
                op_lui: rf_we = 1'b1;
                op_opimm: begin
                    rf_we    = (funct3 == funct3_addi);
                    rf_wdata = rs1_val + imm_i;
                end
                op_load: begin
                    rf_we    = is_load && step == wait_data && bus_rsp.valid;
                    rf_wdata = bus_rsp.rdata;
                end
                op_system: begin
                    rf_we    = is_csrrw;           // old csr value to rd
                    rf_wdata = csr_rdata;
                end
                default: rf_we = 1'b0;
            endcase
        end
        if (rd == 5'd0)
            rf_we = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rf_we)
            regs[rd] <= rf_wdata;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc        <= reset_vector;
            ir        <= nop_instr;
            bubble    <= 1'b1;                     // nothing valid in ir yet
            step      <= idle;
            bus_req   <= '0;
            irq_ack   <= 1'b0;
            mstatus   <= '0;
            mtvec     <= '0;
            mepc      <= '0;
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
            irq_ack   <= 1'b0;
            bubble    <= 1'b0;
            if (!stall) begin                      // fetch
                pc <= pc + 64'd4;
                ir <= instr;
            end
            if (take_irq) begin
                mepc                     <= pc - 64'd4;   // address of ir
                pc                       <= mtvec;
                mstatus[mstatus_mie_bit] <= 1'b0;
                irq_ack                  <= 1'b1;
                bubble                   <= 1'b1;
                bus_req.valid            <= 1'b0;  // drop unaccepted ld
                step                     <= idle;
            end else if (mem_op) begin
                case (step)
                    idle: begin
                        bus_req.addr  <= rs1_val + (is_store ? imm_s : imm_i);
                        bus_req.wdata <= rs2_val;
                        bus_req.write <= is_store;
                        bus_req.valid <= 1'b1;
                        step          <= wait_accept;
                    end
                    wait_accept: if (bus_ready) begin
                        bus_req.valid <= 1'b0;
                        step          <= is_store ? idle : wait_data;
                    end
                    wait_data: if (bus_rsp.valid)
                        step <= idle;
                    default: step <= idle;
                endcase
            end else if (is_csrrw) begin
                case (csr_sel)
                    csr_mstatus: mstatus <= rs1_val;
                    csr_mtvec:   mtvec   <= rs1_val;   // no redirect
                    csr_mepc:    mepc    <= rs1_val;
                    default:     mepc    <= mepc;
                endcase
            end else if (is_mret) begin
                pc                       <= mepc;
                mstatus[mstatus_mie_bit] <= 1'b1;
                bubble                   <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/instr_rom.sv
`timescale 1ns/1ps

module instr_rom import rv_isa_pkg::*, soc_map_pkg::*; (
    input  logic [xlen-1:0] pc,
    output logic [31:0]     instr
);

    logic [31:0]       mem [rom_words];
    logic [xlen-3:0]   word_addr;          // pc in instruction words
    logic              in_range;

    // program image, main loop at reset_vector
    initial begin
        $readmemh("program.hex", mem);
    end

    assign word_addr = pc[xlen-1:2];
    assign in_range  = (word_addr < rom_words);

    // past the end reads as nop
    assign instr = in_range ? mem[pc[rom_aw+1:2]] : nop_instr;

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import soc_map_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  bus_req_t             bus_req,
    output logic                 bus_ready,
    output bus_rsp_t             bus_rsp,
    input  logic [key_width-1:0] key_data,
    input  logic                 key_valid,
    output logic                 key_ready,
    output logic [art_width-1:0] art_data,
    output logic                 art_valid,
    input  logic                 art_ready
);

    logic [63:0]       ram [ram_words];     // scratch ram, doublewords
    logic [ram_aw-1:0] ram_idx;
    logic              hit_ram, hit_key, hit_art;
    logic              accept, rd_accept;
    logic [63:0]       rd_data;
    logic [63:0]       rsp_rdata;
    logic              rsp_valid;

    // page compare
    assign hit_ram = bus_req.addr[63:region_bits] == ram_base[63:region_bits];
    assign hit_key = bus_req.addr[63:region_bits] == key_base[63:region_bits];
    assign hit_art = bus_req.addr[63:region_bits] == art_base[63:region_bits];
    assign ram_idx = bus_req.addr[ram_aw+2:3];  // 8-byte words

    // key read waits for a key, art write waits for the sink
    always_comb begin
        bus_ready = 1'b1;                       // ram and unmapped never stall
        if (hit_key && !bus_req.write)
            bus_ready = key_valid;
        else if (hit_art && bus_req.write)
            bus_ready = art_ready;
    end

    assign accept    = bus_req.valid && bus_ready;
    assign rd_accept = accept && !bus_req.write;

    // key is consumed by the accepted read
    assign key_ready = bus_req.valid && !bus_req.write && hit_key && key_valid;
    assign art_valid = bus_req.valid && bus_req.write && hit_art;
    assign art_data  = bus_req.wdata[art_width-1:0];   // low byte only

    always_comb begin
        if (hit_ram)
            rd_data = ram[ram_idx];
        else if (hit_key)
            rd_data = key_data;
        else
            rd_data = '0;                       // unmapped or art read
    end

    always_ff @(posedge clk) begin
        if (accept && bus_req.write && hit_ram)
            ram[ram_idx] <= bus_req.wdata;
        if (rd_accept)
            rsp_rdata <= rd_data;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_accept;             // data one cycle after accept
    end

    assign bus_rsp = '{rdata: rsp_rdata, valid: rsp_valid};

endmodule

// File: verilog/irq_latch.sv
`timescale 1ns/1ps

module irq_latch (
    input  logic clk,
    input  logic reset,
    input  logic irq_line,      // async, from outside
    input  logic irq_ack,       // from core on handler entry
    output logic irq_pending
);

    logic [1:0] sync_q;         // two-flop synchronizer
    logic       line_prev;      // last synced level
    logic       rise;

    assign rise = sync_q[1] && !line_prev;  // held line gives one edge

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sync_q      <= 2'b00;
            line_prev   <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], irq_line};
            line_prev <= sync_q[1];
            // a new edge wins over a same-cycle ack
            if (rise)
                irq_pending <= 1'b1;
            else if (irq_ack)
                irq_pending <= 1'b0;
        end
    end

endmodule

// File: verilog/rv_soc.sv
`timescale 1ns/1ps

module rv_soc import rv_isa_pkg::*, soc_map_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [key_width-1:0] key_data,
    input  logic                 key_valid,
    output logic                 key_ready,
    output logic [art_width-1:0] art_data,
    output logic                 art_valid,
    input  logic                 art_ready,
    input  logic                 irq_line,
    output logic                 heartbeat
);

    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    bus_req_t        bus_req;
    bus_rsp_t        bus_rsp;
    logic            bus_ready;
    logic            irq_pending, irq_ack;

    rv_core u_core (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .pc          (pc),
        .bus_req     (bus_req),
        .bus_ready   (bus_ready),
        .bus_rsp     (bus_rsp),
        .irq_pending (irq_pending),
        .irq_ack     (irq_ack),
        .heartbeat   (heartbeat)
    );

    instr_rom u_rom (
        .pc    (pc),
        .instr (instr)
    );

    // ram, key port and art port behind one handshake
    bus_decoder u_bus (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rsp   (bus_rsp),
        .key_data  (key_data),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .art_data  (art_data),
        .art_valid (art_valid),
        .art_ready (art_ready)
    );

    irq_latch u_irq (
        .clk         (clk),
        .reset       (reset),
        .irq_line    (irq_line),
        .irq_ack     (irq_ack),
        .irq_pending (irq_pending)
    );

endmodule

// File: testbench/tb_rv_soc.sv
`timescale 1ns/1ps

module tb_rv_soc;

    localparam int wait_limit = 300;          // cycles allowed per handshake

    logic        clk = 1'b0;
    logic        reset;
    logic [63:0] key_data;
    logic        key_valid, key_ready;
    logic [7:0]  art_data;
    logic        art_valid, art_ready;
    logic        irq_line, heartbeat;

    logic [31:0] lfsr_state = 32'h3612c9f7;
    int          checks = 0;
    int          errors = 0;
    int          test_start = 0;              // error count when a test began

    rv_soc u_rv_soc (
        .clk       (clk),
        .reset     (reset),
        .key_data  (key_data),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .art_data  (art_data),
        .art_valid (art_valid),
        .art_ready (art_ready),
        .irq_line  (irq_line),
        .heartbeat (heartbeat)
    );

    always #4 clk = ~clk;                     // 8 ns period

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            value      = {value[62:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // no key and no art traffic, heartbeat still alive
    task automatic check_quiet(input int cycles);
        logic last_beat;
        @(negedge clk);
        last_beat = heartbeat;
        repeat (cycles) begin
            @(negedge clk);
            check_value("art_valid", art_valid, 1'b0);
            check_value("key_ready", key_ready, 1'b0);
            check_value("heartbeat", heartbeat, !last_beat);
            last_beat = heartbeat;
        end
        @(posedge clk);
    endtask

    task automatic send_key(input logic [63:0] value);
        int waited;
        waited = 0;
        @(posedge clk);
        key_data  <= value;
        key_valid <= 1'b1;
        @(negedge clk);
        while (!key_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (key_ready) else begin
            errors++;
            $display("timeout at %0t: the core never took key %h", $time, value);
        end
        @(posedge clk);
        key_valid <= 1'b0;                    // consumed on this edge
    endtask

    // hold = cycles the sink stalls once a character shows up
    task automatic expect_art(input logic [7:0] expected, input int hold);
        int         waited;
        logic [7:0] first;
        waited = 0;
        @(posedge clk);
        art_ready <= 1'b0;
        @(negedge clk);
        while (!art_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (art_valid) else begin
            errors++;
            $display("timeout at %0t: no character came out, wanted %h", $time, expected);
        end
        first = art_data;
        repeat (hold) begin
            @(negedge clk);
            check_value("art_valid", art_valid, 1'b1);   // core must keep it up
            check_value("art_data", art_data, first);
        end
        @(posedge clk);
        art_ready <= 1'b1;
        @(negedge clk);
        checks++;
        assert (art_valid && art_data === expected) else begin
            errors++;
            $display("mismatch at %0t: art_data got %h expected %h", $time, art_data, expected);
        end
        @(posedge clk);
        art_ready <= 1'b0;                    // taken on this edge
        @(negedge clk);
        check_value("art_valid", art_valid, 1'b0);   // sent once, not repeated
    endtask

    task automatic report_test(input string name);
        $display("test %s: %s", name, (errors == test_start) ? "ok" : "errors found");
    endtask

    task automatic idle_after_reset();
        test_start = errors;
        check_quiet(40);                      // core parks on its first key read
        report_test("reset idle");
    endtask

    task automatic key_echo();
        logic [63:0] key, pick;
        test_start = errors;
        send_key(64'h0123_4567_89ab_cdff);    // low byte wraps to 00
        expect_art(8'h00, 0);
        repeat (5) begin
            draw_bits(64, key);
            draw_bits(1, pick);
            send_key(key);
            expect_art(key[7:0] + 8'd1, pick[0] ? 3 : 0);
        end
        report_test("key echo");
    endtask

    task automatic art_back_pressure();
        logic [63:0] key, hold;
        test_start = errors;
        repeat (3) begin
            draw_bits(64, key);
            draw_bits(4, hold);
            send_key(key);
            expect_art(key[7:0] + 8'd1, 4 + int'(hold));
        end
        report_test("back pressure");
    endtask

    task automatic irq_during_key_wait();
        logic [63:0] key;
        test_start = errors;
        check_quiet(5);
        @(posedge clk);
        irq_line <= 1'b1;
        expect_art(8'h21, 0);                 // handler output
        check_quiet(30);                      // only one handler run
        @(posedge clk);
        irq_line <= 1'b0;
        draw_bits(64, key);
        send_key(key);                        // loop resumed through mepc
        expect_art(key[7:0] + 8'd1, 2);
        report_test("irq while waiting");
    endtask

    task automatic held_irq_line();
        logic [63:0] key;
        test_start = errors;
        @(posedge clk);
        irq_line <= 1'b1;
        expect_art(8'h21, 1);
        check_quiet(60);                      // line still high, no repeat
        @(posedge clk);
        irq_line <= 1'b0;
        check_quiet(6);
        @(posedge clk);
        irq_line <= 1'b1;                     // new rising edge
        expect_art(8'h21, 0);
        check_quiet(20);
        @(posedge clk);
        irq_line <= 1'b0;
        draw_bits(64, key);
        send_key(key);
        expect_art(key[7:0] + 8'd1, 0);
        report_test("held irq");
    endtask

    initial begin
        reset     = 1'b0;
        key_data  = '0;
        key_valid = 1'b0;
        art_ready = 1'b0;
        irq_line  = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        idle_after_reset();
        key_echo();
        art_back_pressure();
        irq_during_key_wait();
        held_irq_line();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // last resort if a wait loop misbehaves
    initial begin
        repeat (100000) @(posedge clk);
        $display("run went past its cycle budget");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: program.hex
// one 32-bit instruction word per line, lowest address first
// @ lines set the word address, which is pc / 4
@10
02100513 // 0x40 handler: addi x10, x0, 0x21
000035b7 // lui  x11, 0x3        art_base
00a5b023 // sd   x10, 0(x11)
30200073 // mret
@20
04000093 // 0x80 addi x1, x0, 0x40  handler address
30509073 // csrrw x0, mtvec, x1
0a000113 // addi x2, x0, 0xa0      loop address
00002237 // lui  x4, 0x2           key_base
000012b7 // lui  x5, 0x1           ram_base
00003337 // lui  x6, 0x3           art_base
00800193 // addi x3, x0, 8         mie mask
30019073 // csrrw x0, mstatus, x3  irq on
00023383 // 0xa0 ld x7, 0(x4)      wait for a key
00138393 // addi x7, x7, 1
0072b023 // sd   x7, 0(x5)
0002b403 // ld   x8, 0(x5)
00833023 // sd   x8, 0(x6)         low byte out
30001073 // csrrw x0, mstatus, x0  irq off across the jump
34111073 // csrrw x0, mepc, x2
30200073 // mret, back to 0xa0 with irq on

// File: project.f
verilog/rv_isa_pkg.sv
verilog/soc_map_pkg.sv
verilog/rv_core.sv
verilog/instr_rom.sv
verilog/bus_decoder.sv
verilog/irq_latch.sv
verilog/rv_soc.sv
testbench/tb_rv_soc.sv

// File: run_sim.sh
#!/bin/sh
# build the rv_soc testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_rv_soc -o sim_tb_rv_soc
output=$(./obj_dir/sim_tb_rv_soc)
echo "$output"
if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
